/* flist.f */
src/fetch_pkg.sv
src/fetch_region_decode.sv
src/cache_ram.sv
src/icache_ways.sv
src/icache_ctrl.sv
src/fetch_result.sv
src/instr_fetch_top.sv
test/tb_instr_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_instr_fetch
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass message shows up in the output
run: $(BIN)
	./$(BIN) | awk '{ print } /^No errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_instr_fetch.sv */
module tb_instr_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          WAYS      = 4;
    localparam int          INDEX_W   = 8;
    localparam int          CLEAR_CYC = 2**INDEX_W + 2;  // Tag clearing plus turn-around
    localparam int          TIMEOUT   = 50;              // Cycles per fetch
    localparam logic [31:0] WORD_KEY  = 32'hA5C3_0F69;   // Bus memory pattern
    localparam logic [31:0] IDLE_WORD = 32'hFFEE_DDCC;   // Output with no valid fetch

    logic         i_clk;
    logic         i_rst_n;
    logic [31:0]  i_iaddress;
    logic         i_iaddress_valid;
    logic [31:0]  i_iaddress_nxt;
    logic         i_system_rdy;
    logic         i_cache_enable;
    logic         i_cache_flush;
    logic [31:0]  i_cacheable_area;
    logic         i_mem_stall;
    logic         i_exec_stall;
    logic         i_conflict;
    logic [31:0]  o_fetch_instruction;
    logic         o_fetch_stall;
    logic         o_wb_req;
    logic [31:0]  o_wb_address;
    logic [127:0] i_wb_read_data;
    logic         i_wb_ready;

    bit           resident [logic [27:0]];  // Lines the model holds in the cache
    logic [19:0]  tag_pool [4];
    logic [7:0]   index_pool [8];           // Few sets and at most 3 cacheable tags per set

    instr_fetch_top #(
        .WAYS    (WAYS),
        .INDEX_W (INDEX_W)
    ) dut (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_iaddress          (i_iaddress),
        .i_iaddress_valid    (i_iaddress_valid),
        .i_iaddress_nxt      (i_iaddress_nxt),
        .i_system_rdy        (i_system_rdy),
        .i_cache_enable      (i_cache_enable),
        .i_cache_flush       (i_cache_flush),
        .i_cacheable_area    (i_cacheable_area),
        .i_mem_stall         (i_mem_stall),
        .i_exec_stall        (i_exec_stall),
        .i_conflict          (i_conflict),
        .o_fetch_instruction (o_fetch_instruction),
        .o_fetch_stall       (o_fetch_stall),
        .o_wb_req            (o_wb_req),
        .o_wb_address        (o_wb_address),
        .i_wb_read_data      (i_wb_read_data),
        .i_wb_ready          (i_wb_ready)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        model_word = {2'b00, addr[31:2]} ^ WORD_KEY;   // Scrambled word address
    endfunction

    function automatic logic is_cacheable(input logic [31:0] addr, input logic [31:0] mask);
        is_cacheable = (addr < 32'h0FFF_FFFF) && mask[addr[25:21]];
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // Bus memory answers 0 to 3 cycles after the request
    initial
    begin : bus_model
        int          delay;
        logic [31:0] base;
        i_wb_ready     = 1'b0;
        i_wb_read_data = '0;
        forever
        begin
            @(negedge i_clk);
            i_wb_ready = 1'b0;
            #2;
            if (o_wb_req)
            begin
                delay = $urandom % 4;
                base  = {o_wb_address[31:4], 4'h0};
                repeat (delay) @(negedge i_clk);
                @(negedge i_clk);
                for (int i = 0; i < 4; i++)
                    i_wb_read_data[i*32 +: 32] = model_word(base + 32'(i * 4));
                i_wb_ready = 1'b1;               // Whole line in a single beat
            end
        end
    end

    // Stall holds for the whole clearing with no bus traffic
    task automatic check_clear_period();
        int count;
        count = 0;
        #1;
        while (o_fetch_stall)
        begin
            assert (!o_wb_req)
            else report_error($sformatf("CHECK FAILED: o_wb_req = %h, expected 0", o_wb_req));
            count++;
            if (count > 4 * CLEAR_CYC)
                report_error("Timeout: stall never dropped after tag clearing");
            @(negedge i_clk);
            #1;
        end
        assert (count == CLEAR_CYC)
        else report_error($sformatf("CHECK FAILED: o_fetch_stall cycles = %h, expected %h",
                                    count, CLEAR_CYC));
    endtask

    // One fetch with the address announced a cycle ahead on i_iaddress_nxt
    task automatic fetch_one(input logic [31:0] addr, input logic en,
                             input logic [31:0] mask, output logic saw_req);
        int          cycles;
        logic        cached;
        logic [31:0] exp_word;
        cached   = is_cacheable(addr, mask) && en;
        exp_word = model_word(addr);
        @(negedge i_clk);
        i_iaddress_valid = 1'b0;
        i_iaddress_nxt   = addr;
        i_cache_enable   = en;
        i_cacheable_area = mask;
        #1;
        assert (o_fetch_instruction == IDLE_WORD)
        else report_error($sformatf("CHECK FAILED: o_fetch_instruction = %h, expected %h",
                                    o_fetch_instruction, IDLE_WORD));
        @(negedge i_clk);
        i_iaddress       = addr;
        i_iaddress_valid = 1'b1;
        saw_req = 1'b0;
        cycles  = 0;
        #1;
        forever
        begin
            if (o_wb_req)
            begin
                saw_req = 1'b1;
                assert (o_wb_address == addr)
                else report_error($sformatf("CHECK FAILED: o_wb_address = %h, expected %h",
                                            o_wb_address, addr));
            end
            if (!o_fetch_stall)
                break;                               // Accepted on the next rising edge
            cycles++;
            if (cycles > TIMEOUT)
                report_error($sformatf("Timeout: fetch of %h never completed", addr));
            @(negedge i_clk);
            #1;
        end
        assert (o_fetch_instruction == exp_word)
        else report_error($sformatf("CHECK FAILED: o_fetch_instruction = %h, expected %h",
                                    o_fetch_instruction, exp_word));
        if (cached)
        begin
            assert (saw_req == !resident.exists(addr[31:4]))
            else report_error($sformatf("CHECK FAILED: o_wb_req = %h, expected %h",
                                        saw_req, !resident.exists(addr[31:4])));
            resident[addr[31:4]] = 1'b1;
        end
        else
        begin
            assert (saw_req)
            else report_error($sformatf("CHECK FAILED: o_wb_req = %h, expected 1", saw_req));
        end
    endtask

    function automatic logic [31:0] random_addr();
        random_addr = {tag_pool[2'($urandom)], index_pool[3'($urandom)],
                       2'($urandom), 2'b00};
    endfunction

    // ========================================
    // Main sequence
    // ========================================
    initial
    begin : main
        logic        saw_req;
        logic [31:0] addr;
        i_rst_n          = 1'b0;
        i_iaddress       = '0;
        i_iaddress_valid = 1'b0;
        i_iaddress_nxt   = '0;
        i_system_rdy     = 1'b1;
        i_cache_enable   = 1'b1;
        i_cache_flush    = 1'b0;
        i_cacheable_area = '1;
        i_mem_stall      = 1'b0;
        i_exec_stall     = 1'b0;
        i_conflict       = 1'b0;
        void'($urandom(40));
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_clear_period();

        for (int i = 0; i < 3; i++)
            tag_pool[i] = {4'h0, 16'($urandom)};    // Main memory
        tag_pool[3] = {4'hF, 16'($urandom)};        // Above the limit
        for (int i = 0; i < 8; i++)
            index_pool[i] = 8'($urandom);

        // System not ready holds the stall
        @(negedge i_clk);
        i_system_rdy = 1'b0;
        repeat (5)
        begin
            #1;
            assert (o_fetch_stall)
            else report_error($sformatf("CHECK FAILED: o_fetch_stall = %h, expected 1",
                                        o_fetch_stall));
            @(negedge i_clk);
        end
        i_system_rdy = 1'b1;

        // Random mix of cached and uncached fetches
        for (int n = 0; n < 400; n++)
            fetch_one(random_addr(), ($urandom % 4) != 0, $urandom, saw_req);

        // Cache off or area masked goes to the bus
        for (int n = 0; n < 20; n++)
        begin
            fetch_one(random_addr(), 1'b0, '1, saw_req);
            fetch_one(random_addr(), 1'b1, '0, saw_req);
        end

        // Repeat from the line just filled
        addr = {tag_pool[0], index_pool[0], 4'h0};
        fetch_one(addr, 1'b1, '1, saw_req);
        fetch_one(addr | 32'h8, 1'b1, '1, saw_req);
        assert (!saw_req)
        else report_error($sformatf("CHECK FAILED: o_wb_req = %h, expected 0", saw_req));

        // Flush drops every line
        @(negedge i_clk);
        i_iaddress_valid = 1'b0;
        i_cache_flush    = 1'b1;
        @(negedge i_clk);
        i_cache_flush = 1'b0;
        check_clear_period();
        resident.delete();
        fetch_one(addr, 1'b1, '1, saw_req);
        assert (saw_req)
        else report_error($sformatf("CHECK FAILED: o_wb_req = %h, expected 1", saw_req));

        @(negedge i_clk);
        i_iaddress_valid = 1'b0;
        $display("No errors");
        $finish;
    end

endmodule

/* src/instr_fetch_top.sv */
module instr_fetch_top
    import fetch_pkg::*;
#(
    parameter int WAYS    = 4,
    parameter int INDEX_W = 8                 // 256 lines per way
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    // Core side
    input  logic [ADDR_W-1:0]  i_iaddress,
    input  logic               i_iaddress_valid,
    input  logic [ADDR_W-1:0]  i_iaddress_nxt,
    input  logic               i_system_rdy,
    input  logic               i_cache_enable,
    input  logic               i_cache_flush,
    input  logic [31:0]        i_cacheable_area,
    input  logic               i_mem_stall,
    input  logic               i_exec_stall,
    input  logic               i_conflict,
    output logic [INSTR_W-1:0] o_fetch_instruction,
    output logic               o_fetch_stall,
    // Bus side
    output logic               o_wb_req,
    output logic [ADDR_W-1:0]  o_wb_address,
    input  logic [LINE_W-1:0]  i_wb_read_data,
    input  logic               i_wb_ready
);

    localparam int TAG_W = ADDR_W - INDEX_W - INDEX_LSB;

    logic               sel_cache;
    logic               uncached_read;
    logic               core_stall;
    logic               cache_stall;
    logic               cache_req;
    logic               idle;
    logic [LINE_W-1:0]  cache_line;
    logic [LINE_W-1:0]  hit_line;
    logic [INDEX_W-1:0] index;
    logic [TAG_W:0]     tag_wdata;
    logic [WAYS-1:0]    tag_we;
    logic [WAYS-1:0]    data_we;
    logic [WAYS-1:0]    hit_way;
    logic [WAYS-1:0]    valid_bits;

    // Whole pipe frozen by any of these
    assign core_stall = o_fetch_stall || i_mem_stall || i_exec_stall || i_conflict;

    fetch_region_decode u_decode (
        .i_iaddress       (i_iaddress),
        .i_iaddress_valid (i_iaddress_valid),
        .i_cache_enable   (i_cache_enable),
        .i_cacheable_area (i_cacheable_area),
        .i_cache_stall    (cache_stall),
        .o_sel_cache      (sel_cache),
        .o_uncached_read  (uncached_read)
    );

    // ========================================
    // L1 instruction cache
    // ========================================
    icache_ctrl #(
        .WAYS    (WAYS),
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cache_flush  (i_cache_flush),
        .i_core_stall   (core_stall),
        .i_select       (sel_cache),
        .i_cache_enable (i_cache_enable),
        .i_address      (i_iaddress),
        .i_address_nxt  (i_iaddress_nxt),
        .i_hit_way      (hit_way),
        .i_hit_line     (hit_line),
        .i_valid_bits   (valid_bits),
        .i_wb_read_data (i_wb_read_data),
        .i_wb_ready     (i_wb_ready),
        .o_index        (index),
        .o_tag_wdata    (tag_wdata),
        .o_tag_we       (tag_we),
        .o_data_we      (data_we),
        .o_idle         (idle),
        .o_cache_req    (cache_req),
        .o_cache_stall  (cache_stall),
        .o_cache_line   (cache_line)
    );

    icache_ways #(
        .WAYS    (WAYS),
        .INDEX_W (INDEX_W)
    ) u_ways (
        .i_clk        (i_clk),
        .i_index      (index),
        .i_tag_wdata  (tag_wdata),
        .i_tag_we     (tag_we),
        .i_data_we    (data_we),
        .i_line_wdata (i_wb_read_data),       // Fill straight from the bus beat
        .i_address    (i_iaddress),
        .i_idle       (idle),
        .o_hit_way    (hit_way),
        .o_hit_line   (hit_line),
        .o_valid_bits (valid_bits)
    );

    fetch_result u_result (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_iaddress          (i_iaddress),
        .i_sel_cache         (sel_cache),
        .i_uncached_read     (uncached_read),
        .i_cache_line        (cache_line),
        .i_cache_req         (cache_req),
        .i_wb_read_data      (i_wb_read_data),
        .i_wb_ready          (i_wb_ready),
        .i_system_rdy        (i_system_rdy),
        .i_cache_stall       (cache_stall),
        .o_fetch_instruction (o_fetch_instruction),
        .o_fetch_stall       (o_fetch_stall),
        .o_wb_req            (o_wb_req),
        .o_wb_address        (o_wb_address)
    );

endmodule

/* src/fetch_result.sv */
module fetch_result
    import fetch_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [ADDR_W-1:0]  i_iaddress,
    input  logic               i_sel_cache,
    input  logic               i_uncached_read,
    input  logic [LINE_W-1:0]  i_cache_line,
    input  logic               i_cache_req,
    input  logic [LINE_W-1:0]  i_wb_read_data,
    input  logic               i_wb_ready,
    input  logic               i_system_rdy,
    input  logic               i_cache_stall,
    output logic [INSTR_W-1:0] o_fetch_instruction,
    output logic               o_fetch_stall,
    output logic               o_wb_req,
    output logic [ADDR_W-1:0]  o_wb_address
);

    logic [WORD_SEL_W-1:0] word_sel;
    logic [INSTR_W-1:0]    cache_word;
    logic [INSTR_W-1:0]    bus_word;
    logic                  wb_wait_r;
    logic                  wait_wb;

    // Word out of a 16-byte line
    function automatic logic [INSTR_W-1:0] pick_word(
        input logic [LINE_W-1:0]     line,
        input logic [WORD_SEL_W-1:0] sel
    );
        pick_word = line[sel*INSTR_W +: INSTR_W];
    endfunction

    assign word_sel   = i_iaddress[WORD_SEL_LSB +: WORD_SEL_W];
    assign cache_word = pick_word(i_cache_line, word_sel);
    assign bus_word   = pick_word(i_wb_read_data, word_sel);

    assign o_fetch_instruction = i_sel_cache     ? cache_word :
                                 i_uncached_read ? bus_word   :
                                                   FETCH_IDLE_WORD;

    // ========================================
    // Bus request and wait
    // ========================================
    assign o_wb_req     = i_cache_req || i_uncached_read;
    assign o_wb_address = i_iaddress;         // Line aligned by the bus

    // Request seen, no ready yet
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            wb_wait_r <= 1'b0;
        else
            wb_wait_r <= o_wb_req && !i_wb_ready;
    end

    assign wait_wb = (o_wb_req || wb_wait_r) && !i_wb_ready;

    // Any of the three holds the core
    assign o_fetch_stall = !i_system_rdy || wait_wb || i_cache_stall;

endmodule

/* src/icache_ctrl.sv */
module icache_ctrl
    import fetch_pkg::*;
#(
    parameter int WAYS    = 4,
    parameter int INDEX_W = 8
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_cache_flush,
    input  logic                              i_core_stall,
    input  logic                              i_select,
    input  logic                              i_cache_enable,
    input  logic [ADDR_W-1:0]                 i_address,
    input  logic [ADDR_W-1:0]                 i_address_nxt,  // Address of next cycle
    input  logic [WAYS-1:0]                   i_hit_way,
    input  logic [LINE_W-1:0]                 i_hit_line,
    input  logic [WAYS-1:0]                   i_valid_bits,
    input  logic [LINE_W-1:0]                 i_wb_read_data,
    input  logic                              i_wb_ready,
    output logic [INDEX_W-1:0]                o_index,
    output logic [ADDR_W-INDEX_W-INDEX_LSB:0] o_tag_wdata,
    output logic [WAYS-1:0]                   o_tag_we,
    output logic [WAYS-1:0]                   o_data_we,
    output logic                              o_idle,
    output logic                              o_cache_req,
    output logic                              o_cache_stall,
    output logic [LINE_W-1:0]                 o_cache_line
);

    localparam int TAG_W = ADDR_W - INDEX_W - INDEX_LSB;
    localparam int WAY_W = $clog2(WAYS);

    cache_state_t      state;
    logic [INDEX_W:0]  init_count;            // One extra bit marks the end of clearing
    logic              busy_r;
    logic [3:0]        lfsr_r;
    logic [ADDR_W-1:0] miss_addr;
    logic [ADDR_W-1:0] address_c;
    logic [ADDR_W-1:0] address_r;
    logic [LINE_W-1:0] rbuf_data;
    logic [ADDR_W-1:0] rbuf_addr;
    logic              rbuf_valid;
    logic              enable;
    logic              hit;
    logic              read_miss;
    logic              fill_write;
    logic              wb_hit;
    logic              rbuf_hit;
    logic              read_stall;
    logic [WAYS-1:0]   fill_way;

    // RAM address, held address while the core is frozen
    assign address_c = i_core_stall ? i_address : i_address_nxt;

    assign enable     = i_select && i_cache_enable;
    assign hit        = |i_hit_way;
    assign fill_write = (state == CS_FILL) && i_wb_ready;     // Line beat arrives
    assign rbuf_hit   = rbuf_valid && (i_address[ADDR_W-1:INDEX_LSB] == rbuf_addr[ADDR_W-1:INDEX_LSB]);
    assign wb_hit     = fill_write && (i_address[ADDR_W-1:INDEX_LSB] == miss_addr[ADDR_W-1:INDEX_LSB]);

    // address_r check drops lookups on a RAM read of some other address
    assign read_miss = (state == CS_IDLE) && enable && !hit && !rbuf_hit
                       && (address_r == i_address);

    // ========================================
    // Cache FSM and clearing counter
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_cache_flush)        // Flush restarts the clearing
        begin
            state      <= CS_INIT;
            init_count <= '0;
            busy_r     <= 1'b1;
            lfsr_r     <= LFSR_SEED;
        end
        else
        begin
            busy_r <= (state == CS_INIT);     // Covers the turn-around after clearing too
            case (state)
                CS_INIT:
                    if (init_count[INDEX_W])
                        state <= CS_TURN_AROUND;
                    else
                        init_count <= init_count + 1'b1;
                CS_IDLE:
                    if (read_miss)
                    begin
                        state  <= CS_FILL;
                        lfsr_r <= {lfsr_r[2:0], lfsr_r[3] ^ lfsr_r[2]};
                    end
                CS_FILL:
                    if (i_wb_ready)
                        state <= CS_FILL_DONE;
                CS_FILL_DONE:   state <= CS_TURN_AROUND;
                CS_TURN_AROUND: state <= CS_IDLE;
                default:        state <= CS_IDLE;
            endcase
        end
    end

    // Miss address follows the core while idle
    always_ff @(posedge i_clk)
    begin
        address_r <= address_c;
        if (state == CS_IDLE)
            miss_addr <= i_address;
    end

    // ========================================
    // Way replacement
    // ========================================
    // Lowest invalid way first, else the LFSR pick
    always_comb
    begin
        fill_way = '0;
        fill_way[lfsr_r[WAY_W-1:0]] = 1'b1;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (!i_valid_bits[w])
            begin
                fill_way    = '0;
                fill_way[w] = 1'b1;
            end
        end
    end

    // RAM controls
    assign o_index     = (state == CS_INIT) ? init_count[INDEX_W-1:0] :
                         (state == CS_FILL) ? miss_addr[INDEX_LSB +: INDEX_W] :
                                              address_c[INDEX_LSB +: INDEX_W];
    assign o_tag_wdata = (state == CS_INIT) ? '0 : {1'b1, miss_addr[ADDR_W-1 -: TAG_W]};
    assign o_tag_we    = (state == CS_INIT) ? '1 : (fill_write ? fill_way : '0);
    assign o_data_we   = fill_write ? fill_way : '0;
    assign o_idle      = (state == CS_IDLE);

    // ========================================
    // Read buffer, last filled line
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_cache_flush)
            rbuf_valid <= 1'b0;
        else if (fill_write)
            rbuf_valid <= 1'b1;
        else if (read_miss)
            rbuf_valid <= 1'b0;               // New miss replaces it
    end

    always_ff @(posedge i_clk)
    begin
        if (fill_write)
        begin
            rbuf_data <= i_wb_read_data;
            rbuf_addr <= miss_addr;
        end
    end

    // Bus beat first, then buffer, then RAM
    assign o_cache_line = wb_hit   ? i_wb_read_data :
                          rbuf_hit ? rbuf_data      :
                                     i_hit_line;

    assign o_cache_req   = read_miss || (state == CS_FILL);   // Level until the beat
    assign read_stall    = enable && !hit && !wb_hit && !rbuf_hit;
    assign o_cache_stall = busy_r || read_stall;

endmodule

/* src/icache_ways.sv */
module icache_ways
    import fetch_pkg::*;
#(
    parameter int WAYS    = 4,
    parameter int INDEX_W = 8
) (
    input  logic                                    i_clk,
    input  logic [INDEX_W-1:0]                      i_index,
    input  logic [ADDR_W-INDEX_W-INDEX_LSB:0]       i_tag_wdata,   // Valid bit on top
    input  logic [WAYS-1:0]                         i_tag_we,
    input  logic [WAYS-1:0]                         i_data_we,
    input  logic [LINE_W-1:0]                       i_line_wdata,
    input  logic [ADDR_W-1:0]                       i_address,
    input  logic                                    i_idle,
    output logic [WAYS-1:0]                         o_hit_way,
    output logic [LINE_W-1:0]                       o_hit_line,
    output logic [WAYS-1:0]                         o_valid_bits
);

    localparam int TAG_W = ADDR_W - INDEX_W - INDEX_LSB;

    logic [TAG_W:0]      tag_rdata  [WAYS];
    logic [LINE_W-1:0]   data_rdata [WAYS];
    logic [WAYS-1:0]     valid;
    logic [TAG_W-1:0]    addr_tag;

    assign addr_tag = i_address[ADDR_W-1 -: TAG_W];

    // ========================================
    // One tag and one data RAM per way
    // ========================================
    for (genvar w = 0; w < WAYS; w++)
    begin : g_way
        cache_ram #(
            .DATA_W     (TAG_W + 1),
            .ADDR_W_RAM (INDEX_W)
        ) u_tag (
            .i_clk   (i_clk),
            .i_we    (i_tag_we[w]),
            .i_addr  (i_index),
            .i_wdata (i_tag_wdata),
            .o_rdata (tag_rdata[w])
        );

        cache_ram #(
            .DATA_W     (LINE_W),
            .ADDR_W_RAM (INDEX_W)
        ) u_data (
            .i_clk   (i_clk),
            .i_we    (i_data_we[w]),
            .i_addr  (i_index),
            .i_wdata (i_line_wdata),
            .o_rdata (data_rdata[w])
        );

        assign valid[w] = tag_rdata[w][TAG_W];
        // Compare only in IDLE, RAM output is stale in the other states
        assign o_hit_way[w] = i_idle && valid[w] && (tag_rdata[w][TAG_W-1:0] == addr_tag);
    end

    // Hit is one-hot, AND-OR mux
    always_comb
    begin
        o_hit_line = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            o_hit_line |= data_rdata[w] & {LINE_W{o_hit_way[w]}};
        end
    end

    // Valid bits of the missing set, frozen once the fill starts
    always_ff @(posedge i_clk)
    begin
        if (i_idle)
        begin
            o_valid_bits <= valid;
        end
    end

endmodule

/* src/cache_ram.sv */
module cache_ram #(
    parameter int DATA_W     = 32,
    parameter int ADDR_W_RAM = 8
) (
    input  logic                  i_clk,
    input  logic                  i_we,
    input  logic [ADDR_W_RAM-1:0] i_addr,
    input  logic [DATA_W-1:0]     i_wdata,
    output logic [DATA_W-1:0]     o_rdata
);

    logic [DATA_W-1:0] mem [2**ADDR_W_RAM];

    // Single port, read returns the old contents on a write cycle
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];               // Registered read
    end

endmodule

/* src/fetch_region_decode.sv */
module fetch_region_decode
    import fetch_pkg::*;
(
    input  logic [ADDR_W-1:0] i_iaddress,
    input  logic              i_iaddress_valid,
    input  logic              i_cache_enable,
    input  logic [31:0]       i_cacheable_area,   // One bit per 2 MB area
    input  logic              i_cache_stall,
    output logic              o_sel_cache,
    output logic              o_uncached_read
);

    logic [AREA_W-1:0] area_idx;
    logic              below_limit;
    logic              area_ok;
    logic              cacheable;

    // Area index picks the mask bit
    assign area_idx    = i_iaddress[AREA_LSB +: AREA_W];
    assign below_limit = i_iaddress < MAIN_LIMIT;
    assign area_ok     = i_cacheable_area[area_idx];
    assign cacheable   = below_limit && area_ok;

    // Cache path only with the cache switched on
    assign o_sel_cache = cacheable && i_iaddress_valid && i_cache_enable;

    // Everything else goes to the bus
    // Held off while the cache is busy, e.g. during tag clearing
    assign o_uncached_read = !o_sel_cache && i_iaddress_valid && !i_cache_stall;

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

    // ========================================
    // Data path widths
    // ========================================
    localparam int ADDR_W  = 32;              // Byte address, one word wide
    localparam int INSTR_W = 32;
    localparam int LINE_W  = 128;             // Cache line and bus beat

    // Address fields
    localparam int WORD_SEL_LSB = 2;          // Word within line
    localparam int WORD_SEL_W   = 2;
    localparam int INDEX_LSB    = 4;          // Line index starts above the 16-byte offset

    // 2 MB areas, one mask bit each
    localparam int AREA_LSB = 21;
    localparam int AREA_W   = 5;

    // ========================================
    // Memory map and constants
    // ========================================
    // Nothing at or above this is cacheable
    localparam logic [ADDR_W-1:0] MAIN_LIMIT = 32'h0FFF_FFFF;

    // Returned while no fetch is valid
    localparam logic [INSTR_W-1:0] FETCH_IDLE_WORD = 32'hFFEE_DDCC;

    localparam logic [3:0] LFSR_SEED = 4'hF;  // Replacement LFSR start value

    // ========================================
    // Cache FSM
    // ========================================
    typedef enum logic [2:0] {
        CS_INIT,                              // Tag clearing, one line per cycle
        CS_IDLE,                              // Lookup
        CS_FILL,                              // Waiting for the line beat
        CS_FILL_DONE,
        CS_TURN_AROUND                        // RAM read settles for the held address
    } cache_state_t;

endpackage
